// ==== logic/datapathPkg.sv ====
package datapathPkg;

        ////////////////////////////////////////
        // Widths
        ////////////////////////////////////////

        // One data word
        localparam int dataWidth = 16;
        localparam int regCount = 16;
        localparam int regSelWidth = 4;
        localparam int immWidth = 8;

        // Low bits of operand B used by the shifter
        localparam int shiftAmtWidth = 4;

        ////////////////////////////////////////
        // Opcodes and bundles
        ////////////////////////////////////////

        typedef enum logic [3:0] {
                opAdd = 4'd0,
                opSub = 4'd1,
                opAnd = 4'd2,
                opOr  = 4'd3,
                opXor = 4'd4,
                opLdi = 4'd5,
                opShl = 4'd6,
                opShr = 4'd7,
                opSar = 4'd8,
                opNop = 4'd15
        } opcode_t;

        // Issued instruction, 24 bits
        typedef struct packed {
                opcode_t opcode;
                logic [regSelWidth-1:0] dest;
                logic [regSelWidth-1:0] srcA;
                logic [regSelWidth-1:0] srcB;
                logic [immWidth-1:0] imm;
        } instWord_t;

        // Registered output of one execution unit
        typedef struct packed {
                logic valid;
                logic [regSelWidth-1:0] dest;
                logic [dataWidth-1:0] data;
        } unitResult_t;

        // Register file write port
        typedef struct packed {
                logic enable;
                logic [regSelWidth-1:0] select;
                logic [dataWidth-1:0] data;
        } regWrite_t;

        typedef struct packed {
                logic valid;
                logic [regSelWidth-1:0] dest;
                logic [dataWidth-1:0] data;
                logic zero;
        } execResult_t;

endpackage

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
        input  logic clk,
        input  logic reset,
        input  datapathPkg::regWrite_t write,
        input  logic [datapathPkg::regSelWidth-1:0] readSelA,
        input  logic [datapathPkg::regSelWidth-1:0] readSelB,
        output logic [datapathPkg::dataWidth-1:0] readDataA,
        output logic [datapathPkg::dataWidth-1:0] readDataB
);

        logic [datapathPkg::dataWidth-1:0] regs [datapathPkg::regCount];
        logic [datapathPkg::regCount-1:0] writeEnable;

        ////////////////////////////////////////
        // Write decode
        ////////////////////////////////////////

        // One-hot enable with at most one bit set
        always_comb begin
                writeEnable = '0;
                if (write.enable) begin
                        writeEnable[write.select] = 1'b1;
                end
        end

        // Register array
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < datapathPkg::regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < datapathPkg::regCount; i++) begin
                                if (writeEnable[i]) begin
                                        regs[i] <= write.data;
                                end
                        end
                end
        end

        ////////////////////////////////////////
        // Read ports
        ////////////////////////////////////////

        // Operand A
        always_comb begin
                readDataA = regs[readSelA];
        end

        // Operand B
        always_comb begin
                readDataB = regs[readSelB];
        end

        // Checks
        selectKnown: assert property (@(posedge clk) disable iff (reset)
                write.enable |-> !$isunknown(write.select));

endmodule

// ==== logic/arithLogicUnit.sv ====
`timescale 1ns/1ps

module arithLogicUnit (
        input  logic clk,
        input  logic reset,
        input  logic instValid,
        input  datapathPkg::opcode_t opcode,
        input  logic [datapathPkg::regSelWidth-1:0] dest,
        input  logic [datapathPkg::dataWidth-1:0] operandA,
        input  logic [datapathPkg::dataWidth-1:0] operandB,
        input  logic [datapathPkg::immWidth-1:0] imm,
        output datapathPkg::unitResult_t result
);

        logic ownsOp;
        logic [datapathPkg::dataWidth-1:0] aluValue;
        logic resultValid;
        logic [datapathPkg::regSelWidth-1:0] resultDest;
        logic [datapathPkg::dataWidth-1:0] resultData;

        // Opcode decode and the operation itself
        always_comb begin
                ownsOp = 1'b1;
                aluValue = '0;
                case (opcode)
                        datapathPkg::opAdd: aluValue = operandA + operandB;
                        datapathPkg::opSub: aluValue = operandA - operandB;
                        datapathPkg::opAnd: aluValue = operandA & operandB;
                        datapathPkg::opOr: aluValue = operandA | operandB;
                        datapathPkg::opXor: aluValue = operandA ^ operandB;
                        // Zero-extended immediate
                        datapathPkg::opLdi: aluValue = {
                                {(datapathPkg::dataWidth - datapathPkg::immWidth){1'b0}}, imm};
                        default: ownsOp = 1'b0;
                endcase
        end

        ////////////////////////////////////////
        // Output stage
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        resultValid <= 1'b0;
                end else begin
                        resultValid <= instValid && ownsOp;
                end
        end

        // Payload only moves for owned opcodes
        always_ff @(posedge clk) begin
                if (instValid && ownsOp) begin
                        resultDest <= dest;
                        resultData <= aluValue;
                end
        end

        assign result = '{valid: resultValid, dest: resultDest, data: resultData};

endmodule

// ==== logic/shiftUnit.sv ====
`timescale 1ns/1ps

module shiftUnit (
        input  logic clk,
        input  logic reset,
        input  logic instValid,
        input  datapathPkg::opcode_t opcode,
        input  logic [datapathPkg::regSelWidth-1:0] dest,
        input  logic [datapathPkg::dataWidth-1:0] operandA,
        input  logic [datapathPkg::dataWidth-1:0] operandB,
        output datapathPkg::unitResult_t result
);

        logic ownsOp;
        logic [datapathPkg::shiftAmtWidth-1:0] shiftAmt;
        logic [datapathPkg::dataWidth-1:0] shiftValue;
        logic resultValid;
        logic [datapathPkg::regSelWidth-1:0] resultDest;
        logic [datapathPkg::dataWidth-1:0] resultData;

        assign shiftAmt = operandB[datapathPkg::shiftAmtWidth-1:0];

        always_comb begin
                ownsOp = 1'b1;
                shiftValue = '0;
                case (opcode)
                        datapathPkg::opShl: shiftValue = operandA << shiftAmt;
                        datapathPkg::opShr: shiftValue = operandA >> shiftAmt;
                        // Sign fill from bit 15
                        datapathPkg::opSar: shiftValue = $signed(operandA) >>> shiftAmt;
                        default: ownsOp = 1'b0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        resultValid <= 1'b0;
                end else begin
                        resultValid <= instValid && ownsOp;
                end
        end

        always_ff @(posedge clk) begin
                if (instValid && ownsOp) begin
                        resultDest <= dest;
                        resultData <= shiftValue;
                end
        end

        assign result = '{valid: resultValid, dest: resultDest, data: resultData};

        // Non-shift issues never produce a shifter result
        noForeignResult: assert property (@(posedge clk) disable iff (reset)
                instValid && !(opcode inside {datapathPkg::opShl, datapathPkg::opShr,
                        datapathPkg::opSar}) |=> !result.valid);

endmodule

// ==== logic/writebackSelect.sv ====
`timescale 1ns/1ps

module writebackSelect (
        input  logic clk,
        input  logic reset,
        input  datapathPkg::unitResult_t aluResult,
        input  datapathPkg::unitResult_t shiftResult,
        output datapathPkg::regWrite_t write,
        output datapathPkg::execResult_t result
);

        datapathPkg::unitResult_t chosen;
        logic wbValid;
        logic [datapathPkg::regSelWidth-1:0] wbDest;
        logic [datapathPkg::dataWidth-1:0] wbData;
        logic wbZero;

        // At most one unit fires per cycle
        assign chosen = aluResult.valid ? aluResult : shiftResult;

        always_ff @(posedge clk) begin
                if (reset) begin
                        wbValid <= 1'b0;
                end else begin
                        wbValid <= chosen.valid;
                end
        end

        always_ff @(posedge clk) begin
                if (chosen.valid) begin
                        wbDest <= chosen.dest;
                        wbData <= chosen.data;
                        wbZero <= (chosen.data == '0);
                end
        end

        // Same registered value feeds the register file and the port
        assign write = '{enable: wbValid, select: wbDest, data: wbData};
        assign result = '{valid: wbValid, dest: wbDest, data: wbData, zero: wbZero};

        oneSource: assert property (@(posedge clk) disable iff (reset)
                !(aluResult.valid && shiftResult.valid));

endmodule

// ==== logic/executeCore.sv ====
`timescale 1ns/1ps

module executeCore (
        input  logic clk,
        input  logic reset,
        input  logic instValid,
        input  datapathPkg::instWord_t inst,
        output datapathPkg::execResult_t result
);

        logic [datapathPkg::dataWidth-1:0] operandA;
        logic [datapathPkg::dataWidth-1:0] operandB;
        datapathPkg::unitResult_t aluResult;
        datapathPkg::unitResult_t shiftResult;
        datapathPkg::regWrite_t regWrite;

        ////////////////////////////////////////
        // Operand fetch
        ////////////////////////////////////////

        registerFile i_registerFile (
                .clk       (clk),
                .reset     (reset),
                .write     (regWrite),
                .readSelA  (inst.srcA),
                .readSelB  (inst.srcB),
                .readDataA (operandA),
                .readDataB (operandB)
        );

        // Both units see every issue and keep only their own opcodes
        arithLogicUnit i_arithLogicUnit (
                .clk       (clk),
                .reset     (reset),
                .instValid (instValid),
                .opcode    (inst.opcode),
                .dest      (inst.dest),
                .operandA  (operandA),
                .operandB  (operandB),
                .imm       (inst.imm),
                .result    (aluResult)
        );

        shiftUnit i_shiftUnit (
                .clk       (clk),
                .reset     (reset),
                .instValid (instValid),
                .opcode    (inst.opcode),
                .dest      (inst.dest),
                .operandA  (operandA),
                .operandB  (operandB),
                .result    (shiftResult)
        );

        writebackSelect i_writebackSelect (
                .clk         (clk),
                .reset       (reset),
                .aluResult   (aluResult),
                .shiftResult (shiftResult),
                .write       (regWrite),
                .result      (result)
        );

endmodule

// ==== verification/executeModel.svh ====
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

////////////////////////////////////////
// Reference model state
////////////////////////////////////////

// Result expected on the output at cycle due
typedef struct packed {
        int due;
        logic [datapathPkg::regSelWidth-1:0] dest;
        logic [datapathPkg::dataWidth-1:0] data;
        logic zero;
} expectEntry_t;

// Architectural update that becomes visible to issues at applyAt
typedef struct packed {
        int applyAt;
        logic [datapathPkg::regSelWidth-1:0] dest;
        logic [datapathPkg::dataWidth-1:0] data;
} pendingWrite_t;

logic [datapathPkg::dataWidth-1:0] shadowRegs [datapathPkg::regCount];
expectEntry_t expectQueue [$];
pendingWrite_t writeQueue [$];

// Value of one operation from the opcode rules
function automatic logic [15:0] modelValue(input datapathPkg::opcode_t op,
                input logic [15:0] a, input logic [15:0] b, input logic [7:0] imm);
        int amt;
        logic [15:0] value;
        amt = b[3:0];
        case (op)
                datapathPkg::opAdd: value = a + b;
                datapathPkg::opSub: value = a + ~b + 16'd1;
                datapathPkg::opAnd: value = a & b;
                datapathPkg::opOr: value = a | b;
                datapathPkg::opXor: value = a ^ b;
                datapathPkg::opLdi: value = {8'h00, imm};
                datapathPkg::opShl: value = a << amt;
                datapathPkg::opShr: value = a >> amt;
                datapathPkg::opSar: begin
                        value = a >> amt;
                        // Vacated upper bits take the sign
                        if (a[15]) begin
                                value = value | ~(16'hFFFF >> amt);
                        end
                end
                default: value = '0;
        endcase
        return value;
endfunction

// Issue at cycle now, result due 2 later, register visible 3 later
function automatic void issueModel(input int now, input datapathPkg::instWord_t word);
        logic [15:0] value;
        expectEntry_t entry;
        pendingWrite_t pending;
        if (word.opcode != datapathPkg::opNop) begin
                value = modelValue(word.opcode, shadowRegs[word.srcA],
                        shadowRegs[word.srcB], word.imm);
                entry = '{due: now + 2, dest: word.dest, data: value, zero: value == 16'd0};
                pending = '{applyAt: now + 3, dest: word.dest, data: value};
                expectQueue.push_back(entry);
                writeQueue.push_back(pending);
        end
endfunction

function automatic void applyWrites(input int now);
        while (writeQueue.size() != 0 && writeQueue[0].applyAt <= now) begin
                shadowRegs[writeQueue[0].dest] = writeQueue[0].data;
                void'(writeQueue.pop_front());
        end
endfunction

`endif

// ==== verification/executeCoreTb.sv ====
`timescale 1ns/1ps

module executeCoreTb;

        localparam int randomCount = 300;
        localparam int drainLimit = 20;

        logic clk;
        logic reset;
        logic instValid;
        datapathPkg::instWord_t inst;
        datapathPkg::execResult_t result;
        datapathPkg::instWord_t idleWord;

        int cycleCount;
        int checkCount;
        int errorCount;
        int timeoutCount;
        logic [15:0] lfsrState;
        string testName;

        `include "executeModel.svh"

        executeCore i_dut (
                .clk       (clk),
                .reset     (reset),
                .instValid (instValid),
                .inst      (inst),
                .result    (result)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #10 clk = ~clk;
                end
        end

        // Galois LFSR, one step per bit taken
        function automatic int randomBits(input int count);
                int bits;
                logic outBit;
                bits = 0;
                for (int i = 0; i < count; i++) begin
                        outBit = lfsrState[0];
                        lfsrState = lfsrState >> 1;
                        if (outBit) begin
                                lfsrState = lfsrState ^ 16'hB400;
                        end
                        bits = (bits << 1) | int'(outBit);
                end
                return bits;
        endfunction

        task automatic checkValue(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
                checkCount++;
                if (expected !== actual) begin
                        errorCount++;
                        $display("[ERROR] %s %s: expected %h, actual %h", testName, what,
                                expected, actual);
                end
        endtask

        ////////////////////////////////////////
        // Scoreboard and drivers
        ////////////////////////////////////////

        task automatic scoreResult();
                expectEntry_t entry;
                if (expectQueue.size() != 0 && expectQueue[0].due == cycleCount) begin
                        entry = expectQueue.pop_front();
                        checkValue("valid", 32'd1, 32'(result.valid));
                        checkValue("dest", 32'(entry.dest), 32'(result.dest));
                        checkValue("data", 32'(entry.data), 32'(result.data));
                        checkValue("zero", 32'(entry.zero), 32'(result.zero));
                end else begin
                        checkValue("idle valid", 32'd0, 32'(result.valid));
                end
        endtask

        // Outputs are stable at the falling edge, inputs change there too
        task automatic stepCycle(input logic issue, input datapathPkg::instWord_t word);
                @(negedge clk);
                cycleCount++;
                scoreResult();
                applyWrites(cycleCount);
                instValid = issue;
                inst = word;
                if (issue) begin
                        issueModel(cycleCount, word);
                end
        endtask

        task automatic idleCycles(input int count);
                for (int i = 0; i < count; i++) begin
                        stepCycle(1'b0, idleWord);
                end
        endtask

        task automatic issueInst(input datapathPkg::opcode_t op, input int dest, input int srcA,
                        input int srcB, input int imm);
                stepCycle(1'b1, '{opcode: op, dest: 4'(dest), srcA: 4'(srcA), srcB: 4'(srcB),
                        imm: 8'(imm)});
        endtask

        task automatic issueRandom(input logic noGap);
                int index;
                int gap;
                index = randomBits(4) % 10;
                issueInst((index == 9) ? datapathPkg::opNop : datapathPkg::opcode_t'(index),
                        randomBits(4), randomBits(4), randomBits(4), randomBits(8));
                gap = randomBits(2) % 3;
                if (!noGap) begin
                        idleCycles(gap);
                end
        endtask

        // Wait until every expected result and write has gone by
        task automatic drainResults();
                int waited;
                waited = 0;
                while ((expectQueue.size() != 0 || writeQueue.size() != 0)
                                && waited < drainLimit) begin
                        stepCycle(1'b0, idleWord);
                        waited++;
                end
                if (expectQueue.size() != 0 || writeQueue.size() != 0) begin
                        timeoutCount++;
                        $display("Timeout in %s: results still pending", testName);
                end
        endtask

        ////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////

        initial begin
                lfsrState = 16'd51;
                cycleCount = 0;
                checkCount = 0;
                errorCount = 0;
                timeoutCount = 0;
                idleWord = '0;
                idleWord.opcode = datapathPkg::opNop;
                reset = 1'b1;
                instValid = 1'b0;
                inst = idleWord;
                foreach (shadowRegs[i]) begin
                        shadowRegs[i] = '0;
                end
                repeat (5) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                testName = "reset";
                idleCycles(3);
                issueInst(datapathPkg::opLdi, 1, 0, 0, 8'hA5);
                issueInst(datapathPkg::opAdd, 2, 0, 0, 0);
                drainResults();

                // Every write decode, then read back through or with r0
                testName = "loadImmediate";
                for (int i = 0; i < 16; i++) begin
                        issueInst(datapathPkg::opLdi, i, 0, 0, (i == 0) ? 0 : randomBits(8));
                end
                idleCycles(3);
                for (int i = 0; i < 16; i++) begin
                        issueInst(datapathPkg::opOr, i, i, 0, 0);
                end
                drainResults();

                testName = "random";
                for (int n = 0; n < randomCount; n++) begin
                        issueRandom(1'b0);
                end
                drainResults();

                testName = "backToBack";
                for (int n = 0; n < 24; n++) begin
                        issueRandom(1'b1);
                end
                drainResults();

                // Nops leave r3 untouched
                testName = "nop";
                issueInst(datapathPkg::opLdi, 3, 0, 0, 8'h5C);
                for (int n = 0; n < 4; n++) begin
                        issueInst(datapathPkg::opNop, 3, 1, 2, 8'hFF);
                end
                issueInst(datapathPkg::opOr, 4, 3, 0, 0);
                drainResults();

                $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount,
                        timeoutCount);
                if (errorCount == 0 && timeoutCount == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

// ==== sources.f ====
+incdir+verification
logic/datapathPkg.sv
logic/registerFile.sv
logic/arithLogicUnit.sv
logic/shiftUnit.sv
logic/writebackSelect.sv
logic/executeCore.sv
verification/executeCoreTb.sv

// ==== Bender.yml ====
package:
  name: execute_core

sources:
  - logic/datapathPkg.sv
  - logic/registerFile.sv
  - logic/arithLogicUnit.sv
  - logic/shiftUnit.sv
  - logic/writebackSelect.sv
  - logic/executeCore.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/executeCoreTb.sv
